/* Makefile */
TOP = tb_exec_lane

.PHONY: lint sim clean

lint:
	verilator --lint-only -I. --top-module exec_lane exec_pkg.sv operand_forward.sv \
		op_decode.sv add_logic_unit.sv shift_unit.sv result_select.sv exec_lane.sv

sim:
	verilator --binary --timing --top-module $(TOP) -f all.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log
	cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* add_logic_unit.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module add_logic_unit import exec_pkg::*; (
  input  word_t     opnd_a,
  input  word_t     opnd_b,
  input  lane_ctl_t ctl,
  output unit_res_t res
);

  word_t                  b_eff;
  logic [`EXEC_WORD_W:0]  sum64;  // Carry in the top bit
  logic [`EXEC_HALF_W:0]  sum32;
  word_t                  value;
  logic                   carry;

  assign b_eff = ctl.is_sub ? ~opnd_b : opnd_b;

  // Sub is A + ~B + 1
  assign sum64 = {1'b0, opnd_a} + {1'b0, b_eff} + {{`EXEC_WORD_W{1'b0}}, ctl.is_sub};
  assign sum32 = {1'b0, opnd_a[`EXEC_HALF_W-1:0]} + {1'b0, b_eff[`EXEC_HALF_W-1:0]}
               + {{`EXEC_HALF_W{1'b0}}, ctl.is_sub};

  always_comb begin
    carry = 1'b0;
    case (ctl.logic_sel)
      2'd0: begin
        if (ctl.is_32) begin
          value = {{(`EXEC_WORD_W-`EXEC_HALF_W){1'b0}}, sum32[`EXEC_HALF_W-1:0]};
          carry = sum32[`EXEC_HALF_W];
        end else begin
          value = sum64[`EXEC_WORD_W-1:0];
          carry = sum64[`EXEC_WORD_W];
        end
      end
      2'd1:    value = opnd_a & opnd_b;
      2'd2:    value = opnd_a | opnd_b;
      default: value = opnd_a ^ opnd_b;
    endcase
  end

  assign res.value = value;
  assign res.flags = make_flags(value, ctl.is_32, carry);

endmodule

/* all.f */
+incdir+.
exec_pkg.sv
operand_forward.sv
op_decode.sv
add_logic_unit.sv
shift_unit.sv
result_select.sv
exec_lane.sv
exec_checker.sv
tb_exec_lane.sv

/* exec_checker.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_checker import exec_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         issue,
  input  opcode_t      op,
  input  operand_req_t src_a,
  input  operand_req_t src_b,
  input  bus_vec_t     bus,
  input  logic         result_valid,
  input  unit_res_t    result,
  output int           errors,
  output int           results
);

  unit_res_t expect_q[$];
  longint    due_q[$];     // Cycle on which each result is due
  bus_vec_t  bus_prev;
  longint    cycle;

  function automatic word_t pick_operand(operand_req_t req, bus_vec_t now_bus,
                                         bus_vec_t old_bus);
    for (int i = 0; i < `EXEC_NUM_BUS; i++) begin
      if (req.fwd_now[i]) return now_bus[i];
    end
    for (int i = 0; i < `EXEC_NUM_BUS; i++) begin
      if (req.fwd_late[i]) return old_bus[i];
    end
    return req.reg_val;
  endfunction

  function automatic unit_res_t exec_ref(opcode_t code, word_t a, word_t b);
    word_t      v;
    logic       c;
    logic       half;
    logic [5:0] n;
    unit_res_t  r;
    v = '0;
    c = 1'b0;
    half = (code == `EXEC_OP_ADD32) || (code == `EXEC_OP_SUB32) || (code >= `EXEC_OP_SHL32);
    n = half ? {1'b0, b[4:0]} : b[5:0];
    case (code)
      `EXEC_OP_ADD64: {c, v} = {1'b0, a} + {1'b0, b};
      `EXEC_OP_SUB64: {c, v} = {a >= b, a - b};  // Carry set when no borrow
      `EXEC_OP_ADD32: {c, v[31:0]} = {1'b0, a[31:0]} + {1'b0, b[31:0]};
      `EXEC_OP_SUB32: {c, v[31:0]} = {a[31:0] >= b[31:0], a[31:0] - b[31:0]};
      `EXEC_OP_AND:   v = a & b;
      `EXEC_OP_OR:    v = a | b;
      `EXEC_OP_XOR:   v = a ^ b;
      `EXEC_OP_SHL64: v = a << n;
      `EXEC_OP_SHR64: v = a >> n;
      `EXEC_OP_SAR64: v = (a >> n) | (a[63] ? ~(~64'd0 >> n) : 64'd0);
      `EXEC_OP_SHL32: v[31:0] = a[31:0] << n;
      `EXEC_OP_SHR32: v[31:0] = a[31:0] >> n;
      `EXEC_OP_SAR32: v[31:0] = (a[31:0] >> n) | (a[31] ? ~(~32'd0 >> n) : 32'd0);
      default:        v = '0;
    endcase
    r.value = v;
    r.flags = {half ? (v[31:0] == '0) : (v == '0), half ? v[31] : v[63], c};
    return r;
  endfunction

  always @(posedge clk) begin
    unit_res_t exp_res;
    longint    due;
    cycle++;
    if (result_valid) begin
      if (expect_q.size() == 0) begin
        $display("result_valid rose at %0t with no op in flight", $time);
        errors++;
      end else begin
        exp_res = expect_q.pop_front();
        due = due_q.pop_front();
        if (due != cycle) begin
          $display("result at %0t came on cycle %0d instead of %0d", $time, cycle, due);
          errors++;
        end
        if (result !== exp_res) begin
          $display("Error at %0t: expected %h actual %h", $time, exp_res, result);
          errors++;
        end
        results++;
      end
    end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
      $display("result_valid missing at %0t for an op issued two cycles before", $time);
      errors++;
      exp_res = expect_q.pop_front();
      due = due_q.pop_front();
    end
    if (rst_n && issue) begin
      expect_q.push_back(exec_ref(op, pick_operand(src_a, bus, bus_prev),
                                  pick_operand(src_b, bus, bus_prev)));
      due_q.push_back(cycle + 64'd2);
    end
    bus_prev = bus;  // Late copy for the next issue
  end

endmodule

/* exec_lane.sv */
`timescale 1ns/1ps

module exec_lane import exec_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         issue,
  input  opcode_t      op,
  input  operand_req_t src_a,
  input  operand_req_t src_b,
  input  bus_vec_t     bus,
  output logic         result_valid,
  output unit_res_t    result
);

  word_t     opnd_a;
  word_t     opnd_b;
  lane_ctl_t ctl;
  unit_res_t add_res;
  unit_res_t shift_res;

  operand_forward i_operand_forward (
    .clk    (clk),
    .src_a  (src_a),
    .src_b  (src_b),
    .bus    (bus),
    .opnd_a (opnd_a),
    .opnd_b (opnd_b)
  );

  op_decode i_op_decode (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (issue),
    .op    (op),
    .ctl   (ctl)
  );

  // Both units see the same operands
  add_logic_unit i_add_logic_unit (
    .opnd_a (opnd_a),
    .opnd_b (opnd_b),
    .ctl    (ctl),
    .res    (add_res)
  );

  shift_unit i_shift_unit (
    .opnd_a (opnd_a),
    .opnd_b (opnd_b),
    .ctl    (ctl),
    .res    (shift_res)
  );

  result_select i_result_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctl          (ctl),
    .add_res      (add_res),
    .shift_res    (shift_res),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

/* exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

`define EXEC_WORD_W  64
`define EXEC_HALF_W  32
`define EXEC_NUM_BUS 4
`define EXEC_OP_W    4

`define EXEC_OP_ADD64 4'd0
`define EXEC_OP_SUB64 4'd1
`define EXEC_OP_ADD32 4'd2
`define EXEC_OP_SUB32 4'd3
`define EXEC_OP_AND   4'd4
`define EXEC_OP_OR    4'd5
`define EXEC_OP_XOR   4'd6
`define EXEC_OP_SHL64 4'd8
`define EXEC_OP_SHR64 4'd9
`define EXEC_OP_SAR64 4'd10
`define EXEC_OP_SHL32 4'd11
`define EXEC_OP_SHR32 4'd12
`define EXEC_OP_SAR32 4'd13

`endif

/* exec_pkg.sv */
`include "exec_macros.svh"

package exec_pkg;

  typedef logic [`EXEC_WORD_W-1:0]  word_t;
  typedef logic [`EXEC_OP_W-1:0]    opcode_t;
  typedef logic [`EXEC_NUM_BUS-1:0] bus_sel_t; // One-hot
  typedef logic [2:0]               flags_t;   // {zero, sign, carry}

  typedef word_t [`EXEC_NUM_BUS-1:0] bus_vec_t;

  typedef struct packed {
    word_t    reg_val;
    bus_sel_t fwd_now;
    bus_sel_t fwd_late;
  } operand_req_t;

  typedef struct packed {
    logic       valid;
    logic       is_shift;
    logic       is_32;
    logic       is_sub;
    logic [1:0] logic_sel;  // 0 add/sub, 1 and, 2 or, 3 xor
    logic       shift_right;
    logic       shift_arith;
  } lane_ctl_t;

  typedef struct packed {
    word_t  value;
    flags_t flags;
  } unit_res_t;

  // Zero and sign follow the op width
  function automatic flags_t make_flags(word_t value, logic is_32, logic carry);
    logic zero;
    logic sign;
    zero = is_32 ? (value[`EXEC_HALF_W-1:0] == '0) : (value == '0);
    sign = is_32 ? value[`EXEC_HALF_W-1] : value[`EXEC_WORD_W-1];
    return {zero, sign, carry};
  endfunction

endpackage

/* op_decode.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module op_decode import exec_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      issue,
  input  opcode_t   op,
  output lane_ctl_t ctl
);

  lane_ctl_t ctl_d;

  always_comb begin
    ctl_d = '0;
    ctl_d.valid = issue;
    case (op)
      `EXEC_OP_ADD64: ctl_d.logic_sel = 2'd0;
      `EXEC_OP_SUB64: ctl_d.is_sub = 1'b1;
      `EXEC_OP_ADD32: ctl_d.is_32 = 1'b1;
      `EXEC_OP_SUB32: begin
        ctl_d.is_32  = 1'b1;
        ctl_d.is_sub = 1'b1;
      end
      `EXEC_OP_AND: ctl_d.logic_sel = 2'd1;
      `EXEC_OP_OR:  ctl_d.logic_sel = 2'd2;
      `EXEC_OP_XOR: ctl_d.logic_sel = 2'd3;
      `EXEC_OP_SHL64, `EXEC_OP_SHL32: begin
        ctl_d.is_shift = 1'b1;
        ctl_d.is_32    = (op == `EXEC_OP_SHL32);
      end
      `EXEC_OP_SHR64, `EXEC_OP_SHR32: begin
        ctl_d.is_shift    = 1'b1;
        ctl_d.shift_right = 1'b1;
        ctl_d.is_32       = (op == `EXEC_OP_SHR32);
      end
      `EXEC_OP_SAR64, `EXEC_OP_SAR32: begin
        ctl_d.is_shift    = 1'b1;
        ctl_d.shift_right = 1'b1;
        ctl_d.shift_arith = 1'b1;
        ctl_d.is_32       = (op == `EXEC_OP_SAR32);
      end
      default: ctl_d.logic_sel = 2'd0; // Unused codes fall back to add
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctl <= '0;
    end else begin
      ctl <= ctl_d;
    end
  end

endmodule

/* operand_forward.sv */
`timescale 1ns/1ps

module operand_forward import exec_pkg::*; (
  input  logic         clk,
  input  operand_req_t src_a,
  input  operand_req_t src_b,
  input  bus_vec_t     bus,
  output word_t        opnd_a,
  output word_t        opnd_b
);

  bus_vec_t bus_late;  // Bus values from the previous cycle

  // Current bus beats the late copy, register value is the fallback
  function automatic word_t resolve(operand_req_t req, bus_vec_t now_bus,
                                    bus_vec_t late_bus);
    word_t val;
    val = req.reg_val;
    for (int i = 0; i < $bits(bus_sel_t); i++) begin
      if (req.fwd_late[i]) begin
        val = late_bus[i];
      end
    end
    for (int i = 0; i < $bits(bus_sel_t); i++) begin
      if (req.fwd_now[i]) begin
        val = now_bus[i];
      end
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    bus_late <= bus;
  end

  always_ff @(posedge clk) begin
    opnd_a <= resolve(src_a, bus, bus_late);
    opnd_b <= resolve(src_b, bus, bus_late);
  end

endmodule

/* result_select.sv */
`timescale 1ns/1ps

module result_select import exec_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  lane_ctl_t ctl,
  input  unit_res_t add_res,
  input  unit_res_t shift_res,
  output logic      result_valid,
  output unit_res_t result
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= ctl.valid;
    end
  end

  // Holds the last result between pulses
  always_ff @(posedge clk) begin
    if (ctl.valid) begin
      result <= ctl.is_shift ? shift_res : add_res;
    end
  end

endmodule

/* shift_unit.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module shift_unit import exec_pkg::*; (
  input  word_t     opnd_a,
  input  word_t     opnd_b,
  input  lane_ctl_t ctl,
  output unit_res_t res
);

  logic [5:0]              amt64;
  logic [4:0]              amt32;
  logic [`EXEC_HALF_W-1:0] a32;
  logic [`EXEC_HALF_W-1:0] res32;
  word_t                   res64;
  word_t                   value;

  assign amt64 = opnd_b[5:0];
  assign amt32 = opnd_b[4:0];
  assign a32   = opnd_a[`EXEC_HALF_W-1:0];

  always_comb begin
    if (!ctl.shift_right) begin
      res64 = opnd_a << amt64;
      res32 = a32 << amt32;
    end else if (ctl.shift_arith) begin
      res64 = $signed(opnd_a) >>> amt64;
      res32 = $signed(a32) >>> amt32;  // Fills with bit 31
    end else begin
      res64 = opnd_a >> amt64;
      res32 = a32 >> amt32;
    end
  end

  assign value = ctl.is_32 ? {{(`EXEC_WORD_W-`EXEC_HALF_W){1'b0}}, res32} : res64;

  assign res.value = value;
  assign res.flags = make_flags(value, ctl.is_32, 1'b0);

endmodule

/* tb_exec_lane.sv */
`timescale 1ns/1ps
`include "exec_macros.svh"

module tb_exec_lane import exec_pkg::*; ();

  logic         clk = 1'b0;
  logic         rst_n;
  logic         issue;
  opcode_t      op;
  operand_req_t src_a;
  operand_req_t src_b;
  bus_vec_t     bus;
  logic         result_valid;
  unit_res_t    result;
  int           errors;
  int           results;
  int           err_mark;
  int           res_mark;
  int           issued;
  int           tests_ok;
  int           tests_bad;
  logic         fault;

  exec_lane i_exec_lane (.*);

  exec_checker i_exec_checker (.*);

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic operand_req_t reg_req(word_t v);
    operand_req_t r;
    r = '0;
    r.reg_val = v;
    return r;
  endfunction

  // Register value, current bus or previous-cycle bus
  function automatic operand_req_t rand_req();
    operand_req_t r;
    int           mode;
    r = reg_req(rand_word());
    mode = $urandom_range(0, 2);
    if (mode == 1) r.fwd_now = bus_sel_t'(1 << $urandom_range(0, 3));
    if (mode == 2) r.fwd_late = bus_sel_t'(1 << $urandom_range(0, 3));
    return r;
  endfunction

  function automatic opcode_t rand_op(int top);
    opcode_t code;
    code = opcode_t'($urandom_range(0, top));
    return (code >= 4'd7) ? code + 4'd1 : code;  // Skips unused code 7
  endfunction

  task automatic next_cycle();
    @(negedge clk);
    issue = 1'b0;
    for (int i = 0; i < `EXEC_NUM_BUS; i++) bus[i] = rand_word();
  endtask

  task automatic send(opcode_t code, operand_req_t a, operand_req_t b);
    next_cycle();
    issue = 1'b1;
    op = code;
    src_a = a;
    src_b = b;
    issued++;
  endtask

  task automatic begin_test();
    err_mark = errors;
    res_mark = results;
    issued = 0;
    fault = 1'b0;
  endtask

  task automatic end_test(string name);
    int n;
    n = 0;
    next_cycle();
    while (results - res_mark < issued && n < 10) begin
      next_cycle();
      n++;
    end
    if (results - res_mark != issued) begin
      $display("no result_valid within 10 cycles, %0d ops issued but %0d results seen",
               issued, results - res_mark);
      fault = 1'b1;
    end
    if (!fault && errors == err_mark) begin
      $display("%s: ok", name);
      tests_ok++;
    end else begin
      $display("%s: FAIL", name);
      tests_bad++;
    end
  endtask

  initial begin
    word_t        a;
    operand_req_t ra;
    operand_req_t rb;
    int           amts[4];
    void'($urandom(32'hce5833e6));
    amts = '{0, 31, 32, 63};
    rst_n = 1'b0;
    issue = 1'b0;
    op = '0;
    src_a = '0;
    src_b = '0;
    bus = '0;
    repeat (3) next_cycle();
    rst_n = 1'b1;

    begin_test();
    repeat (10) begin
      next_cycle();
      if (result_valid) fault = 1'b1;
    end
    if (fault) $display("result_valid went high with no op issued");
    end_test("reset_idle");

    begin_test();
    send(`EXEC_OP_ADD64, reg_req('1), reg_req(64'd1));  // Wraps to zero with carry
    send(`EXEC_OP_SUB64, reg_req(64'd5), reg_req(64'd5));
    send(`EXEC_OP_SUB64, reg_req(64'd0), reg_req(64'd1));  // Borrow
    send(`EXEC_OP_ADD32, reg_req(64'hABCD_0000_FFFF_FFFF), reg_req(64'd1));
    send(`EXEC_OP_SUB32, reg_req(64'h1234_5678_0000_0003), reg_req(64'd5));
    send(`EXEC_OP_ADD64, reg_req(64'h8000_0000_0000_0000), reg_req(64'h8000_0000_0000_0000));
    repeat (200) begin
      send(rand_op(3), reg_req(rand_word()), reg_req(rand_word()));
      if ($urandom_range(0, 3) == 0) next_cycle();
    end
    end_test("arith");

    begin_test();
    for (int k = 4; k <= 6; k++) send(opcode_t'(k), reg_req(rand_word()), reg_req(rand_word()));
    for (int k = 8; k <= 13; k++) begin
      foreach (amts[j]) begin
        a = rand_word() | 64'h8000_0000_8000_0000;  // Negative in both widths
        send(opcode_t'(k), reg_req(a), reg_req(word_t'(amts[j])));
        send(opcode_t'(k), reg_req(a >> 1), reg_req(rand_word()));
      end
    end
    end_test("logic_shift");

    begin_test();
    for (int k = 0; k < `EXEC_NUM_BUS; k++) begin
      ra = reg_req(rand_word());
      rb = reg_req(rand_word());
      ra.fwd_now = bus_sel_t'(1 << k);
      rb.fwd_late = bus_sel_t'(1 << k);
      send(rand_op(12), ra, rb);
      send(rand_op(12), rb, ra);
    end
    repeat (60) begin
      send(rand_op(12), rand_req(), rand_req());
      next_cycle();
    end
    end_test("forwarding");

    begin_test();
    repeat (100) send(rand_op(12), rand_req(), rand_req());
    end_test("back_to_back");

    $display("summary: %0d ok, %0d failing, %0d errors", tests_ok, tests_bad, errors);
    if (tests_bad == 0 && errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
